// File: sources.f
riscv_pkg.sv
instr_decoder.sv
alu.sv
reg_file.sv
pc_unit.sv
riscv_core.sv
tb_riscv_core.sv

// File: tb_riscv_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_riscv_core;

    localparam int  RESET_CYCLES = 3;
    localparam time HALF_PERIOD  = 50;   // 100 ns clock
    localparam time DRIVE_DLY    = 10;   // inputs change this long after the edge

    // opcodes used to build the program
    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] LUI    = 7'b0110111;
    localparam logic [6:0] AUIPC  = 7'b0010111;
    localparam logic [6:0] JALR   = 7'b1100111;
    localparam logic [6:0] LOAD   = 7'b0000011;   // not supported by the core

    typedef struct packed {
        riscv_pkg::word_t     pc;        // address the row is fetched from
        riscv_pkg::word_t     instr;
        logic                 we;        // expected trace
        riscv_pkg::reg_addr_t rd;
        riscv_pkg::word_t     data;
        logic                 illegal;
    } row_t;

    logic             CLK;
    logic             RESET;
    riscv_pkg::word_t instr;
    riscv_pkg::word_t pc;
    riscv_pkg::wb_t   wb;
    logic             illegal;

    row_t rows [$];
    int   pass_count = 0;
    int   fail_count = 0;
    int   cycles     = 0;

    riscv_core i_dut (
        .CLK       (CLK),
        .RESET     (RESET),
        .instr_i   (instr),
        .pc_o      (pc),
        .wb_o      (wb),
        .illegal_o (illegal)
    );

    initial begin
        CLK = 1'b0;
        forever #HALF_PERIOD CLK = ~CLK;
    end

    //////////////////////////////////////////////////
    // instruction encoders
    //////////////////////////////////////////////////
    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_word(input logic [6:0] opc, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};   // shift forms put funct7 in imm[11:5]
    endfunction

    function automatic logic [31:0] b_word(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_word(input logic [6:0] opc, input logic [4:0] rd,
                                           input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_word(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    //////////////////////////////////////////////////
    // table rows
    //////////////////////////////////////////////////
    task automatic write_row(input logic [31:0] at, input logic [31:0] word,
                             input logic [4:0] rd, input logic [31:0] data);
        rows.push_back('{pc: at, instr: word, we: 1'b1, rd: rd, data: data, illegal: 1'b0});
    endtask

    // no register write expected, only pc flow and the illegal flag
    task automatic silent_row(input logic [31:0] at, input logic [31:0] word,
                              input logic ill);
        rows.push_back('{pc: at, instr: word, we: 1'b0, rd: '0, data: '0, illegal: ill});
    endtask

    task automatic build_table();
        silent_row(32'h00, 32'h0, 1'b1);                                     // zero word
        write_row(32'h04, i_word(OP_IMM, 3'b000, 1, 0, 12'd5), 1, 32'd5);
        write_row(32'h08, i_word(OP_IMM, 3'b000, 2, 0, 12'hFFD), 2, 32'hFFFF_FFFD);
        write_row(32'h0C, i_word(OP_IMM, 3'b000, 3, 0, 12'h7F0), 3, 32'h0000_07F0);
        write_row(32'h10, r_word(7'h00, 3'b000, 4, 1, 2), 4, 32'd2);         // add
        write_row(32'h14, r_word(7'h20, 3'b000, 5, 1, 2), 5, 32'd8);         // sub
        write_row(32'h18, r_word(7'h00, 3'b111, 6, 2, 3), 6, 32'h7F0);       // and
        write_row(32'h1C, r_word(7'h00, 3'b110, 7, 1, 3), 7, 32'h7F5);       // or
        write_row(32'h20, r_word(7'h00, 3'b100, 8, 2, 3), 8, 32'hFFFF_F80D); // xor
        write_row(32'h24, r_word(7'h00, 3'b001, 9, 1, 1), 9, 32'hA0);        // sll by 5
        write_row(32'h28, r_word(7'h00, 3'b101, 10, 2, 1), 10, 32'h07FF_FFFF);
        write_row(32'h2C, r_word(7'h20, 3'b101, 11, 2, 1), 11, 32'hFFFF_FFFF);
        write_row(32'h30, r_word(7'h00, 3'b010, 12, 2, 1), 12, 32'd1);       // -3 < 5
        write_row(32'h34, r_word(7'h00, 3'b011, 13, 2, 1), 13, 32'd0);       // unsigned big
        write_row(32'h38, i_word(OP_IMM, 3'b010, 14, 2, 12'hFFE), 14, 32'd1);
        write_row(32'h3C, i_word(OP_IMM, 3'b011, 15, 1, 12'hFFF), 15, 32'd1);
        write_row(32'h40, i_word(OP_IMM, 3'b100, 16, 1, 12'h0FF), 16, 32'hFA);
        write_row(32'h44, i_word(OP_IMM, 3'b110, 17, 1, 12'h100), 17, 32'h105);
        write_row(32'h48, i_word(OP_IMM, 3'b111, 18, 2, 12'h0F0), 18, 32'hF0);
        write_row(32'h4C, i_word(OP_IMM, 3'b001, 19, 1, 12'h004), 19, 32'h50);
        write_row(32'h50, i_word(OP_IMM, 3'b101, 20, 2, 12'h01C), 20, 32'hF);
        write_row(32'h54, i_word(OP_IMM, 3'b101, 21, 2, 12'h401), 21, 32'hFFFF_FFFE);
        write_row(32'h58, u_word(LUI, 22, 20'h12345), 22, 32'h1234_5000);
        write_row(32'h5C, u_word(AUIPC, 23, 20'h00001), 23, 32'h0000_105C);
        silent_row(32'h60, i_word(OP_IMM, 3'b000, 0, 1, 12'd7), 1'b0);     // x0 target
        write_row(32'h64, r_word(7'h00, 3'b000, 24, 0, 1), 24, 32'd5);       // x0 still 0
        // branches, taken then not taken
        silent_row(32'h68, b_word(3'b000, 1, 1, 13'd8), 1'b0);              // beq
        silent_row(32'h70, b_word(3'b000, 1, 2, 13'd8), 1'b0);
        silent_row(32'h74, b_word(3'b001, 1, 2, 13'd12), 1'b0);             // bne
        silent_row(32'h80, b_word(3'b001, 1, 1, 13'd8), 1'b0);
        silent_row(32'h84, b_word(3'b100, 2, 1, 13'd8), 1'b0);              // blt
        silent_row(32'h8C, b_word(3'b100, 1, 2, 13'd8), 1'b0);
        silent_row(32'h90, b_word(3'b101, 1, 2, 13'd8), 1'b0);              // bge
        silent_row(32'h98, b_word(3'b101, 2, 1, 13'd8), 1'b0);
        silent_row(32'h9C, b_word(3'b110, 1, 2, 13'd8), 1'b0);              // bltu
        silent_row(32'hA4, b_word(3'b110, 2, 1, 13'd8), 1'b0);
        silent_row(32'hA8, b_word(3'b111, 2, 1, 13'd8), 1'b0);              // bgeu
        silent_row(32'hB0, b_word(3'b111, 1, 2, 13'd8), 1'b0);
        // jumps and a backward branch
        write_row(32'hB4, j_word(25, 21'd16), 25, 32'hB8);
        write_row(32'hC4, i_word(JALR, 3'b000, 26, 1, 12'h100), 26, 32'hC8); // 0x105 -> 0x104
        silent_row(32'h104, b_word(3'b000, 0, 0, 13'h1FE0), 1'b0);          // -0x20
        write_row(32'hE4, j_word(27, 21'h1F_FFDC), 27, 32'hE8);             // -0x24
        // illegal words, all fall through by four
        silent_row(32'hC0, i_word(LOAD, 3'b010, 1, 0, 12'd0), 1'b1);
        silent_row(32'hC4, r_word(7'h01, 3'b000, 28, 1, 1), 1'b1);          // bad funct7
        silent_row(32'hC8, r_word(7'h20, 3'b111, 28, 1, 1), 1'b1);          // alt on and
        silent_row(32'hCC, b_word(3'b010, 1, 1, 13'd8), 1'b1);              // bad funct3
        silent_row(32'hD0, i_word(OP_IMM, 3'b001, 28, 1, 12'h402), 1'b1);   // slli alt
        // read back the link registers and x1
        write_row(32'hD4, i_word(OP_IMM, 3'b000, 28, 26, 12'd0), 28, 32'hC8);
        write_row(32'hD8, i_word(OP_IMM, 3'b000, 29, 25, 12'd0), 29, 32'hB8);
        write_row(32'hDC, i_word(OP_IMM, 3'b000, 30, 1, 12'd0), 30, 32'd5);
    endtask

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////
    task automatic check_reset();
        int bad;
        bad = 0;
        instr = i_word(OP_IMM, 3'b000, 1, 0, 12'd5);   // legal write, must stay gated
        #1;
        assert (wb.we === 1'b0 && pc === 32'h0) else begin
            $display("mismatch at %0t: in reset we %b pc %h", $time, wb.we, pc);
            bad++;
        end
        if (bad == 0) pass_count++;
        else fail_count++;
        $display("reset      we %b pc %h %s", wb.we, pc, (bad == 0) ? "ok" : "FAILED");
    endtask

    task automatic run_row(input int n);
        row_t r;
        int   bad;
        r   = rows[n];
        bad = 0;
        assert (pc === r.pc) else begin
            $display("mismatch at %0t: row %0d pc %h expected %h", $time, n, pc, r.pc);
            bad++;
        end
        instr = r.instr;
        #1;   // decode is combinational
        assert (illegal === r.illegal) else begin
            $display("mismatch at %0t: row %0d illegal %b expected %b",
                     $time, n, illegal, r.illegal);
            bad++;
        end
        assert (wb.we === r.we) else begin
            $display("mismatch at %0t: row %0d we %b expected %b", $time, n, wb.we, r.we);
            bad++;
        end
        if (r.we) begin
            assert (wb.rd === r.rd && wb.data === r.data) else begin
                $display("mismatch at %0t: row %0d x%0d=%h expected x%0d=%h",
                         $time, n, wb.rd, wb.data, r.rd, r.data);
                bad++;
            end
        end
        if (bad == 0) pass_count++;
        else fail_count++;
        $display("row %2d     pc %h instr %h %s", n, r.pc, r.instr,
                 (bad == 0) ? "ok" : "FAILED");
    endtask

    // run limit from table length
    always @(posedge CLK) begin
        cycles++;
        if (cycles > rows.size() + RESET_CYCLES + 10) begin
            $display("timeout: the run did not finish within %0d cycles", cycles - 1);
            $display("test failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////
    initial begin
        RESET = 1'b1;
        instr = '0;
        build_table();
        repeat (RESET_CYCLES - 1) @(posedge CLK);
        #DRIVE_DLY;
        check_reset();
        @(posedge CLK);
        #DRIVE_DLY;
        RESET = 1'b0;   // third edge done
        for (int n = 0; n < rows.size(); n++) begin
            if (n != 0) begin
                @(posedge CLK);
                #DRIVE_DLY;
            end
            run_row(n);
        end
        $display("%0d tests, %0d ok, %0d failing", pass_count + fail_count,
                 pass_count, fail_count);
        if (fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: riscv_core.sv
`timescale 1ns/10ps
`default_nettype none

module riscv_core (
    input  logic             CLK,
    input  logic             RESET,
    input  riscv_pkg::word_t instr_i,     // word at pc_o, same cycle
    output riscv_pkg::word_t pc_o,        // fetch address
    output riscv_pkg::wb_t   wb_o,        // writeback trace
    output logic             illegal_o
);

    riscv_pkg::instr_u instr;
    riscv_pkg::ctrl_t  ctrl;
    riscv_pkg::word_t  rs1_data;
    riscv_pkg::word_t  rs2_data;
    riscv_pkg::word_t  op_a;
    riscv_pkg::word_t  op_b;
    riscv_pkg::word_t  alu_result;
    logic              alu_flag;
    riscv_pkg::word_t  pc;
    riscv_pkg::wb_t    wb;

    assign instr = instr_i;   // same bits, format view

    instr_decoder i_decoder (
        .instr_i (instr),
        .ctrl_o  (ctrl)
    );

    reg_file i_reg_file (
        .CLK        (CLK),
        .RESET      (RESET),
        .rs1_i      (ctrl.rs1),
        .rs2_i      (ctrl.rs2),
        .wb_i       (wb),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    //////////////////////////////////////////////////
    // operand muxes
    //////////////////////////////////////////////////
    always_comb begin
        case (ctrl.op_a_sel)
            riscv_pkg::OP_A_RS1: op_a = rs1_data;
            riscv_pkg::OP_A_PC:  op_a = pc;        // auipc and link
            default:             op_a = '0;        // lui
        endcase
        case (ctrl.op_b_sel)
            riscv_pkg::OP_B_RS2:  op_b = rs2_data;
            riscv_pkg::OP_B_IMM:  op_b = ctrl.imm;
            riscv_pkg::OP_B_FOUR: op_b = riscv_pkg::word_t'(riscv_pkg::INSTR_BYTES);
            default:              op_b = '0;
        endcase
    end

    alu i_alu (
        .op_a_i   (op_a),
        .op_b_i   (op_b),
        .alu_op_i (ctrl.alu_op),
        .result_o (alu_result),
        .flag_o   (alu_flag)
    );

    pc_unit i_pc_unit (
        .CLK        (CLK),
        .RESET      (RESET),
        .ctrl_i     (ctrl),
        .cmp_flag_i (alu_flag),
        .rs1_data_i (rs1_data),
        .pc_o       (pc)
    );

    // writeback shared by reg file and trace, no write while in reset
    assign wb.we   = ctrl.rf_we && !RESET;
    assign wb.rd   = ctrl.rd;
    assign wb.data = alu_result;

    assign wb_o      = wb;
    assign pc_o      = pc;
    assign illegal_o = ctrl.illegal;

endmodule

`default_nettype wire

// File: pc_unit.sv
`timescale 1ns/10ps
`default_nettype none

module pc_unit (
    input  logic              CLK,
    input  logic              RESET,
    input  riscv_pkg::ctrl_t  ctrl_i,       // jump / branch flags and offset
    input  logic              cmp_flag_i,   // branch taken when set
    input  riscv_pkg::word_t  rs1_data_i,   // jalr base
    output riscv_pkg::word_t  pc_o
);

    riscv_pkg::word_t pc_q;
    riscv_pkg::word_t pc_next;
    riscv_pkg::word_t jalr_sum;

    assign jalr_sum = rs1_data_i + ctrl_i.imm;

    //////////////////////////////////////////////////
    // next pc, jalr first
    //////////////////////////////////////////////////
    always_comb begin
        if (ctrl_i.jalr)
            pc_next = {jalr_sum[riscv_pkg::XLEN-1:1], 1'b0};   // bit 0 dropped
        else if (ctrl_i.jal || (ctrl_i.branch && cmp_flag_i))
            pc_next = pc_q + ctrl_i.imm;                       // pc relative
        else
            pc_next = pc_q + riscv_pkg::word_t'(riscv_pkg::INSTR_BYTES);
    end

    always_ff @(posedge CLK) begin
        if (RESET)
            pc_q <= riscv_pkg::RESET_PC;
        else
            pc_q <= pc_next;   // one instruction per cycle
    end

    assign pc_o = pc_q;

endmodule

`default_nettype wire

// File: reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  logic                 CLK,
    input  logic                 RESET,
    input  riscv_pkg::reg_addr_t rs1_i,        // read port a
    input  riscv_pkg::reg_addr_t rs2_i,        // read port b
    input  riscv_pkg::wb_t       wb_i,         // write port
    output riscv_pkg::word_t     rs1_data_o,
    output riscv_pkg::word_t     rs2_data_o
);

    // x0 has no storage
    riscv_pkg::word_t regs [1:riscv_pkg::NUM_REGS-1];

    always_ff @(posedge CLK) begin
        if (RESET) begin
            for (int k = 1; k < riscv_pkg::NUM_REGS; k++) begin
                regs[k] <= '0;
            end
        end else if (wb_i.we && wb_i.rd != '0) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // combinational reads, index 0 forced to zero
    assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

// File: alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  riscv_pkg::word_t   op_a_i,
    input  riscv_pkg::word_t   op_b_i,
    input  riscv_pkg::alu_op_e alu_op_i,
    output riscv_pkg::word_t   result_o,   // arithmetic / logic / shift result
    output logic               flag_o      // compare outcome for branches
);

    logic       lt_s;    // signed less than
    logic       lt_u;    // unsigned less than
    logic       eq;
    logic [4:0] shamt;   // only the low five bits shift

    assign lt_s  = $signed(op_a_i) < $signed(op_b_i);
    assign lt_u  = op_a_i < op_b_i;
    assign eq    = op_a_i == op_b_i;
    assign shamt = op_b_i[4:0];

    //////////////////////////////////////////////////
    // result word
    //////////////////////////////////////////////////
    always_comb begin
        case (alu_op_i)
            riscv_pkg::ALU_ADD:  result_o = op_a_i + op_b_i;
            riscv_pkg::ALU_SUB:  result_o = op_a_i - op_b_i;
            riscv_pkg::ALU_SLL:  result_o = op_a_i << shamt;
            riscv_pkg::ALU_SLT:  result_o = {{(riscv_pkg::XLEN-1){1'b0}}, lt_s};
            riscv_pkg::ALU_SLTU: result_o = {{(riscv_pkg::XLEN-1){1'b0}}, lt_u};
            riscv_pkg::ALU_XOR:  result_o = op_a_i ^ op_b_i;
            riscv_pkg::ALU_SRL:  result_o = op_a_i >> shamt;
            riscv_pkg::ALU_SRA:  result_o = $signed(op_a_i) >>> shamt;   // keep sign
            riscv_pkg::ALU_OR:   result_o = op_a_i | op_b_i;
            riscv_pkg::ALU_AND:  result_o = op_a_i & op_b_i;
            default:             result_o = '0;   // branch compares have no result
        endcase
    end

    //////////////////////////////////////////////////
    // compare flag
    //////////////////////////////////////////////////
    always_comb begin
        case (alu_op_i)
            riscv_pkg::ALU_EQ:   flag_o = eq;
            riscv_pkg::ALU_NE:   flag_o = !eq;
            riscv_pkg::ALU_LT:   flag_o = lt_s;
            riscv_pkg::ALU_GE:   flag_o = !lt_s;
            riscv_pkg::ALU_LTU:  flag_o = lt_u;
            riscv_pkg::ALU_GEU:  flag_o = !lt_u;
            default:             flag_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: instr_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module instr_decoder (
    input  riscv_pkg::instr_u instr_i,   // raw word from fetch
    output riscv_pkg::ctrl_t  ctrl_o     // control for the whole datapath
);

    riscv_pkg::word_t imm_i;
    riscv_pkg::word_t imm_b;
    riscv_pkg::word_t imm_u;
    riscv_pkg::word_t imm_j;
    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;   // also bits 31:25 of a shift immediate

    // funct3 picks the op, alt picks sub / sra
    function automatic riscv_pkg::alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        riscv_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = alt ? riscv_pkg::ALU_SUB : riscv_pkg::ALU_ADD;
            3'b001:  op = riscv_pkg::ALU_SLL;
            3'b010:  op = riscv_pkg::ALU_SLT;
            3'b011:  op = riscv_pkg::ALU_SLTU;
            3'b100:  op = riscv_pkg::ALU_XOR;
            3'b101:  op = alt ? riscv_pkg::ALU_SRA : riscv_pkg::ALU_SRL;
            3'b110:  op = riscv_pkg::ALU_OR;
            default: op = riscv_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode = instr_i.r.opcode;
    assign funct3 = instr_i.r.funct3;
    assign funct7 = instr_i.r.funct7;

    //////////////////////////////////////////////////
    // immediates
    //////////////////////////////////////////////////
    assign imm_i = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
    assign imm_b = {{19{instr_i.b.imm12}}, instr_i.b.imm12, instr_i.b.imm11,
                    instr_i.b.imm10_5, instr_i.b.imm4_1, 1'b0};   // always even
    assign imm_u = {instr_i.u.imm31_12, 12'b0};
    assign imm_j = {{11{instr_i.j.imm20}}, instr_i.j.imm20, instr_i.j.imm19_12,
                    instr_i.j.imm11, instr_i.j.imm10_1, 1'b0};

    //////////////////////////////////////////////////
    // main decode
    //////////////////////////////////////////////////
    always_comb begin
        ctrl_o          = '0;
        ctrl_o.alu_op   = riscv_pkg::ALU_ADD;
        ctrl_o.op_a_sel = riscv_pkg::OP_A_RS1;
        ctrl_o.op_b_sel = riscv_pkg::OP_B_RS2;
        ctrl_o.imm      = imm_i;
        ctrl_o.rs1      = instr_i.r.rs1;      // register fields sit at fixed bits
        ctrl_o.rs2      = instr_i.r.rs2;
        ctrl_o.rd       = instr_i.r.rd;

        case (opcode)
            riscv_pkg::OPC_OP: begin
                ctrl_o.alu_op = arith_op(funct3, funct7[5]);
                ctrl_o.rf_we  = 1'b1;
                if (funct7 != 7'b0000000 && funct7 != 7'b0100000)
                    ctrl_o.illegal = 1'b1;
                else if (funct7 == 7'b0100000 && funct3 != 3'b000 && funct3 != 3'b101)
                    ctrl_o.illegal = 1'b1;   // only sub and sra have the alt bit
            end
            riscv_pkg::OPC_OP_IMM: begin
                // no subi so the alt bit matters only for shifts right
                ctrl_o.alu_op   = arith_op(funct3, funct3 == 3'b101 && funct7[5]);
                ctrl_o.op_b_sel = riscv_pkg::OP_B_IMM;
                ctrl_o.rf_we    = 1'b1;
                if (funct3 == 3'b001 && funct7 != 7'b0000000)
                    ctrl_o.illegal = 1'b1;   // slli
                else if (funct3 == 3'b101 && funct7 != 7'b0000000
                         && funct7 != 7'b0100000)
                    ctrl_o.illegal = 1'b1;   // srli / srai
            end
            riscv_pkg::OPC_LUI: begin
                ctrl_o.op_a_sel = riscv_pkg::OP_A_ZERO;   // 0 + imm
                ctrl_o.op_b_sel = riscv_pkg::OP_B_IMM;
                ctrl_o.imm      = imm_u;
                ctrl_o.rf_we    = 1'b1;
            end
            riscv_pkg::OPC_AUIPC: begin
                ctrl_o.op_a_sel = riscv_pkg::OP_A_PC;
                ctrl_o.op_b_sel = riscv_pkg::OP_B_IMM;
                ctrl_o.imm      = imm_u;
                ctrl_o.rf_we    = 1'b1;
            end
            riscv_pkg::OPC_BRANCH: begin
                ctrl_o.imm    = imm_b;     // target offset, used by pc unit
                ctrl_o.branch = 1'b1;
                case (instr_i.b.funct3)
                    3'b000:  ctrl_o.alu_op = riscv_pkg::ALU_EQ;
                    3'b001:  ctrl_o.alu_op = riscv_pkg::ALU_NE;
                    3'b100:  ctrl_o.alu_op = riscv_pkg::ALU_LT;
                    3'b101:  ctrl_o.alu_op = riscv_pkg::ALU_GE;
                    3'b110:  ctrl_o.alu_op = riscv_pkg::ALU_LTU;
                    default: ctrl_o.alu_op = riscv_pkg::ALU_GEU;
                endcase
                // 010 and 011 are the store encodings of funct3
                if (instr_i.s.funct3 == 3'b010 || instr_i.s.funct3 == 3'b011)
                    ctrl_o.illegal = 1'b1;
            end
            riscv_pkg::OPC_JAL: begin
                ctrl_o.op_a_sel = riscv_pkg::OP_A_PC;     // link = pc + 4
                ctrl_o.op_b_sel = riscv_pkg::OP_B_FOUR;
                ctrl_o.imm      = imm_j;
                ctrl_o.rf_we    = 1'b1;
                ctrl_o.jal      = 1'b1;
            end
            riscv_pkg::OPC_JALR: begin
                ctrl_o.op_a_sel = riscv_pkg::OP_A_PC;
                ctrl_o.op_b_sel = riscv_pkg::OP_B_FOUR;
                ctrl_o.imm      = imm_i;                  // rs1 offset
                ctrl_o.rf_we    = 1'b1;
                ctrl_o.jalr     = 1'b1;
            end
            default: ctrl_o.illegal = 1'b1;               // unknown opcode, zero word too
        endcase

        // illegal word runs as a nop
        if (ctrl_o.illegal) begin
            ctrl_o.rf_we  = 1'b0;
            ctrl_o.branch = 1'b0;
            ctrl_o.jal    = 1'b0;
            ctrl_o.jalr   = 1'b0;
        end
        if (ctrl_o.rd == '0)
            ctrl_o.rf_we = 1'b0;   // x0 is never written
    end

endmodule

`default_nettype wire

// File: riscv_pkg.sv
`default_nettype none

package riscv_pkg;

    //////////////////////////////////////////////////
    // widths and constants
    //////////////////////////////////////////////////
    localparam int unsigned XLEN        = 32;   // data and address width
    localparam int unsigned REG_ADDR_W  = 5;    // register index width
    localparam int unsigned NUM_REGS    = 32;   // x0..x31
    localparam int unsigned INSTR_BYTES = 4;    // sequential pc step

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam word_t RESET_PC = '0;            // first fetch address

    // major opcodes recognized by the decoder
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    //////////////////////////////////////////////////
    // alu and operand selects
    //////////////////////////////////////////////////
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT,
        ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
        ALU_OR, ALU_AND,
        ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU   // compares drive the flag
    } alu_op_e;

    typedef enum logic [1:0] {
        OP_A_RS1  = 2'd0,
        OP_A_PC   = 2'd1,
        OP_A_ZERO = 2'd2   // lui
    } op_a_sel_e;

    typedef enum logic [1:0] {
        OP_B_RS2  = 2'd0,
        OP_B_IMM  = 2'd1,
        OP_B_FOUR = 2'd2   // link value pc + 4
    } op_b_sel_e;

    //////////////////////////////////////////////////
    // instruction formats, msb first
    //////////////////////////////////////////////////
    typedef struct packed {
        logic [6:0] funct7; reg_addr_t rs2; reg_addr_t rs1;
        logic [2:0] funct3; reg_addr_t rd;  logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm; reg_addr_t rs1; logic [2:0] funct3;
        reg_addr_t rd; logic [6:0] opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi; reg_addr_t rs2; reg_addr_t rs1;
        logic [2:0] funct3; logic [4:0] imm_lo; logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic imm12; logic [5:0] imm10_5; reg_addr_t rs2; reg_addr_t rs1;
        logic [2:0] funct3; logic [3:0] imm4_1; logic imm11; logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm31_12; reg_addr_t rd; logic [6:0] opcode;
    } u_fmt_t;

    typedef struct packed {
        logic imm20; logic [9:0] imm10_1; logic imm11; logic [7:0] imm19_12;
        reg_addr_t rd; logic [6:0] opcode;
    } j_fmt_t;

    // one fetched word, read through whichever format the opcode calls for
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    //////////////////////////////////////////////////
    // decoded control and writeback
    //////////////////////////////////////////////////
    typedef struct packed {
        alu_op_e   alu_op;
        op_a_sel_e op_a_sel;
        op_b_sel_e op_b_sel;
        word_t     imm;       // format immediate, sign extended
        logic      rf_we;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        logic      branch;
        logic      jal;
        logic      jalr;
        logic      illegal;
    } ctrl_t;

    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

endpackage

`default_nettype wire
